// File: verilog/tweezer_pkg.sv
package tweezer_pkg;

    // data path widths
    typedef logic signed [15:0] sample_t;
    typedef logic signed [25:0] coeff_t;
    typedef logic signed [27:0] acc_t;
    typedef logic        [15:0] dac_code_t;
    typedef logic        [3:0]  reg_idx_t;

    // register index map, wide coefficients take two slots
    localparam reg_idx_t REG_KP_LO        = 4'd0;
    localparam reg_idx_t REG_KP_HI        = 4'd1;
    localparam reg_idx_t REG_KI_LO        = 4'd2;
    localparam reg_idx_t REG_KI_HI        = 4'd3;
    localparam reg_idx_t REG_SETPOINT     = 4'd4;
    localparam reg_idx_t REG_LIMIT_HI     = 4'd5;
    localparam reg_idx_t REG_LIMIT_LO     = 4'd6;
    localparam reg_idx_t REG_OUT_DISABLED = 4'd7;
    localparam reg_idx_t REG_X_OFFSET     = 4'd8;
    localparam reg_idx_t REG_Y_OFFSET     = 4'd9;
    localparam reg_idx_t REG_Z_OFFSET     = 4'd10;
    localparam reg_idx_t REG_CONTROL      = 4'd11;

    // control register bits
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_RESET_BIT  = 1;

    // bits of the high half that land on top of a coefficient
    localparam int COEFF_HI_BITS = 10;

    // full scale of the ADC
    localparam sample_t SAMPLE_MAX = 16'sh7FFF;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    // offset binary zero for the AD5541A
    localparam dac_code_t DAC_MIDSCALE = 16'h8000;

    // limits come up wide open
    localparam sample_t LIMIT_HI_RST = SAMPLE_MAX;
    localparam sample_t LIMIT_LO_RST = SAMPLE_MIN;

endpackage

// File: verilog/param_regs.sv
`timescale 1ns/1ps

module param_regs
    import tweezer_pkg::*;
(
    input  logic     clk_adc,
    input  logic     rst_n,
    input  logic     cfg_wr_en,
    input  reg_idx_t cfg_wr_addr,
    input  logic [15:0] cfg_wr_data,
    output coeff_t   kp,
    output coeff_t   ki,
    output sample_t  setpoint,
    output sample_t  limit_hi,
    output sample_t  limit_lo,
    output sample_t  out_disabled,
    output sample_t  x_offset,
    output sample_t  y_offset,
    output sample_t  z_offset,
    output logic     pi_enable,
    output logic     pi_reset
);

    // low halves wait here until the high half arrives
    logic [15:0] kp_lo_stage;
    logic [15:0] ki_lo_stage;

    always_ff @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            kp_lo_stage  <= '0;
            ki_lo_stage  <= '0;
            kp           <= '0;
            ki           <= '0;
            setpoint     <= '0;
            limit_hi     <= LIMIT_HI_RST;
            limit_lo     <= LIMIT_LO_RST;
            out_disabled <= '0;
            x_offset     <= '0;
            y_offset     <= '0;
            z_offset     <= '0;
            pi_enable    <= 1'b0;
            pi_reset     <= 1'b0;
        end else begin
            // reset request lasts a single cycle
            pi_reset <= cfg_wr_en && (cfg_wr_addr == REG_CONTROL) && cfg_wr_data[CTRL_RESET_BIT];
            if (cfg_wr_en) begin
                case (cfg_wr_addr)
                    REG_KP_LO:        kp_lo_stage  <= cfg_wr_data;
                    REG_KP_HI:        kp <= {cfg_wr_data[COEFF_HI_BITS-1:0], kp_lo_stage};
                    REG_KI_LO:        ki_lo_stage  <= cfg_wr_data;
                    REG_KI_HI:        ki <= {cfg_wr_data[COEFF_HI_BITS-1:0], ki_lo_stage};
                    REG_SETPOINT:     setpoint     <= cfg_wr_data;
                    REG_LIMIT_HI:     limit_hi     <= cfg_wr_data;
                    REG_LIMIT_LO:     limit_lo     <= cfg_wr_data;
                    REG_OUT_DISABLED: out_disabled <= cfg_wr_data;
                    REG_X_OFFSET:     x_offset     <= cfg_wr_data;
                    REG_Y_OFFSET:     y_offset     <= cfg_wr_data;
                    REG_Z_OFFSET:     z_offset     <= cfg_wr_data;
                    REG_CONTROL:      pi_enable    <= cfg_wr_data[CTRL_ENABLE_BIT];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: verilog/input_conditioner.sv
`timescale 1ns/1ps

module input_conditioner
    import tweezer_pkg::*;
(
    input  logic       clk_adc,
    input  logic       rst_n,
    input  logic       sample_valid,
    input  sample_t    xdiff,
    input  sample_t    ydiff,
    input  sample_t    sum,
    input  sample_t    x_offset,
    input  sample_t    y_offset,
    input  sample_t    z_offset,
    output sample_t    pos_x,
    output sample_t    pos_y,
    output sample_t    pos_z,
    output logic [2:0] sat_flags,
    output logic       pos_valid
);

    // one extra bit catches the overflow, then clip to full scale
    function automatic sample_t sat_sub(sample_t a, sample_t b);
        logic signed [16:0] d;
        d = $signed({a[15], a}) - $signed({b[15], b});
        if (d[16] != d[15]) begin
            return d[16] ? SAMPLE_MIN : SAMPLE_MAX;
        end
        return d[15:0];
    endfunction

    function automatic logic at_full_scale(sample_t v);
        return (v == SAMPLE_MAX) || (v == SAMPLE_MIN);
    endfunction

    always_ff @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            pos_valid <= 1'b0;
            pos_x     <= '0;
            pos_y     <= '0;
            pos_z     <= '0;
            sat_flags <= '0;
        end else begin
            pos_valid <= sample_valid;
            if (sample_valid) begin
                pos_x     <= sat_sub(xdiff, x_offset);
                pos_y     <= sat_sub(ydiff, y_offset);
                pos_z     <= sat_sub(sum, z_offset);
                // flags look at the raw ADC words
                sat_flags <= {at_full_scale(sum), at_full_scale(ydiff), at_full_scale(xdiff)};
            end
        end
    end

endmodule

// File: verilog/pi_controller.sv
`timescale 1ns/1ps

module pi_controller
    import tweezer_pkg::*;
#(
    parameter int COEFF_FRAC = 24
) (
    input  logic    clk_adc,
    input  logic    rst_n,
    input  logic    pos_valid,
    input  sample_t pos_z,
    input  coeff_t  kp,
    input  coeff_t  ki,
    input  sample_t setpoint,
    input  sample_t limit_hi,
    input  sample_t limit_lo,
    input  sample_t out_disabled,
    input  logic    pi_enable,
    input  logic    pi_reset,
    output sample_t ctrl_out,
    output logic    ctrl_valid
);

    // stage 1 products
    logic signed [16:0] error;
    logic signed [42:0] p_full;
    logic signed [42:0] i_full;
    acc_t p_term;
    acc_t i_term;
    logic valid_s1;

    // stage 2 state and sums
    acc_t integ;
    acc_t integ_new;
    acc_t out_clamped;
    acc_t p_only;
    logic reset_hold;

    function automatic acc_t clamp(acc_t v, sample_t hi, sample_t lo);
        acc_t hi_ext;
        acc_t lo_ext;
        hi_ext = acc_t'(hi);
        lo_ext = acc_t'(lo);
        if (v > hi_ext) begin
            return hi_ext;
        end
        if (v < lo_ext) begin
            return lo_ext;
        end
        return v;
    endfunction

    always_comb begin
        error  = $signed({setpoint[15], setpoint}) - $signed({pos_z[15], pos_z});
        p_full = error * kp;
        i_full = error * ki;
    end

    always_ff @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            p_term   <= '0;
            i_term   <= '0;
        end else begin
            valid_s1 <= pos_valid;
            if (pos_valid) begin
                p_term <= acc_t'(p_full >>> COEFF_FRAC);
                i_term <= acc_t'(i_full >>> COEFF_FRAC);
            end
        end
    end

    // integrator is clipped to the same window as the output
    always_comb begin
        integ_new   = clamp(integ + i_term, limit_hi, limit_lo);
        out_clamped = clamp(p_term + integ_new, limit_hi, limit_lo);
        p_only      = clamp(p_term, limit_hi, limit_lo);
    end

    always_ff @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
            ctrl_out   <= '0;
            integ      <= '0;
            reset_hold <= 1'b0;
        end else begin
            ctrl_valid <= valid_s1;
            if (!pi_enable) begin
                integ      <= '0;
                reset_hold <= 1'b0;
                if (valid_s1) begin
                    ctrl_out <= out_disabled;
                end
            end else if (valid_s1) begin
                // first sample after a reset request is proportional only
                if (pi_reset || reset_hold) begin
                    integ    <= '0;
                    ctrl_out <= p_only[15:0];
                end else begin
                    integ    <= integ_new;
                    ctrl_out <= out_clamped[15:0];
                end
                reset_hold <= 1'b0;
            end else if (pi_reset) begin
                integ      <= '0;
                reset_hold <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/dac_ad5541a_serializer.sv
`timescale 1ns/1ps

module dac_ad5541a_serializer
    import tweezer_pkg::*;
#(
    parameter int SCLK_HALF = 2
) (
    input  logic    clk_adc,
    input  logic    rst_n,
    input  logic    ctrl_valid,
    input  sample_t ctrl_out,
    output logic    dac_sclk,
    output logic    dac_cs_n,
    output logic    dac_sdo,
    output logic    dac_busy
);

    localparam int PH_W = (SCLK_HALF > 1) ? $clog2(2 * SCLK_HALF) : 1;
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(2 * SCLK_HALF - 1);
    localparam logic [PH_W-1:0] PH_HALF = PH_W'(SCLK_HALF);

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_GAP} dac_state_t;

    dac_state_t      state;
    logic [PH_W-1:0] phase;
    logic [3:0]      bit_cnt;
    dac_code_t       dac_code;
    dac_code_t       shreg;

    // signed to offset binary
    assign dac_code = dac_code_t'(ctrl_out) + DAC_MIDSCALE;
    assign dac_busy = (state != S_IDLE);

    always_ff @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            phase    <= '0;
            bit_cnt  <= '0;
            dac_cs_n <= 1'b1;
            dac_sclk <= 1'b0;
            dac_sdo  <= 1'b0;
        end else begin
            // pins follow the state one cycle late
            dac_cs_n <= (state != S_SHIFT);
            dac_sclk <= (state == S_SHIFT) && (phase >= PH_HALF);
            dac_sdo  <= (state == S_SHIFT) ? shreg[15] : 1'b0;
            case (state)
                S_IDLE: begin
                    if (ctrl_valid) begin
                        state   <= S_SHIFT;
                        phase   <= '0;
                        bit_cnt <= '0;
                    end
                end
                S_SHIFT: begin
                    if (phase == PH_LAST) begin
                        phase <= '0;
                        if (bit_cnt == 4'd15) begin
                            state <= S_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                S_GAP: begin
                    // cs_n is high for SCLK_HALF cycles before release
                    if (phase == PH_HALF) begin
                        state <= S_IDLE;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            shreg <= '0;
        end else if (state == S_IDLE && ctrl_valid) begin
            shreg <= dac_code;
        end else if (state == S_SHIFT && phase == PH_LAST) begin
            shreg <= {shreg[14:0], 1'b0};
        end
    end

endmodule

// File: verilog/tweezer_top.sv
`timescale 1ns/1ps

module tweezer_top
    import tweezer_pkg::*;
#(
    parameter int COEFF_FRAC = 24,
    parameter int SCLK_HALF  = 2
) (
    input  logic        clk_adc,
    input  logic        rst_n,
    input  logic        cfg_wr_en,
    input  reg_idx_t    cfg_wr_addr,
    input  logic [15:0] cfg_wr_data,
    input  logic        sample_valid,
    input  sample_t     xdiff,
    input  sample_t     ydiff,
    input  sample_t     sum,
    output sample_t     pos_x,
    output sample_t     pos_y,
    output sample_t     pos_z,
    output logic [2:0]  sat_flags,
    output sample_t     ctrl_out,
    output logic        ctrl_valid,
    output logic        dac_sclk,
    output logic        dac_cs_n,
    output logic        dac_sdo,
    output logic        dac_busy
);

    // parameter levels
    coeff_t  kp;
    coeff_t  ki;
    sample_t setpoint;
    sample_t limit_hi;
    sample_t limit_lo;
    sample_t out_disabled;
    sample_t x_offset;
    sample_t y_offset;
    sample_t z_offset;
    logic    pi_enable;
    logic    pi_reset;
    logic    pos_valid;

    param_regs param_regs_i (
        .clk_adc(clk_adc), .rst_n(rst_n),
        .cfg_wr_en(cfg_wr_en), .cfg_wr_addr(cfg_wr_addr), .cfg_wr_data(cfg_wr_data),
        .kp(kp), .ki(ki), .setpoint(setpoint),
        .limit_hi(limit_hi), .limit_lo(limit_lo), .out_disabled(out_disabled),
        .x_offset(x_offset), .y_offset(y_offset), .z_offset(z_offset),
        .pi_enable(pi_enable), .pi_reset(pi_reset)
    );

    input_conditioner input_conditioner_i (
        .clk_adc(clk_adc), .rst_n(rst_n), .sample_valid(sample_valid),
        .xdiff(xdiff), .ydiff(ydiff), .sum(sum),
        .x_offset(x_offset), .y_offset(y_offset), .z_offset(z_offset),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z),
        .sat_flags(sat_flags), .pos_valid(pos_valid)
    );

    pi_controller #(.COEFF_FRAC(COEFF_FRAC)) pi_controller_i (
        .clk_adc(clk_adc), .rst_n(rst_n), .pos_valid(pos_valid), .pos_z(pos_z),
        .kp(kp), .ki(ki), .setpoint(setpoint),
        .limit_hi(limit_hi), .limit_lo(limit_lo), .out_disabled(out_disabled),
        .pi_enable(pi_enable), .pi_reset(pi_reset),
        .ctrl_out(ctrl_out), .ctrl_valid(ctrl_valid)
    );

    dac_ad5541a_serializer #(.SCLK_HALF(SCLK_HALF)) dac_ad5541a_serializer_i (
        .clk_adc(clk_adc), .rst_n(rst_n),
        .ctrl_valid(ctrl_valid), .ctrl_out(ctrl_out),
        .dac_sclk(dac_sclk), .dac_cs_n(dac_cs_n), .dac_sdo(dac_sdo), .dac_busy(dac_busy)
    );

endmodule

// File: verification/tweezer_tb.sv
`timescale 1ns/1ps

module tweezer_tb;
    import tweezer_pkg::*;

    localparam int COEFF_FRAC = 24;
    localparam int SCLK_HALF  = 2;
    localparam int CLK_PERIOD = 40;
    // capture cycle, 16 bits, then the idle gap
    localparam int FRAME_CYC  = 1 + 32 * SCLK_HALF + SCLK_HALF;
    // stimulus cycles, each allowed two DAC frames
    localparam int STIM_CYC   = 200;
    localparam int WATCHDOG_CYC = STIM_CYC * 2 * FRAME_CYC;

    logic        clk_adc = 1'b0;
    logic        rst_n;
    logic        cfg_wr_en;
    reg_idx_t    cfg_wr_addr;
    logic [15:0] cfg_wr_data;
    logic        sample_valid;
    sample_t     xdiff;
    sample_t     ydiff;
    sample_t     sum;
    sample_t     pos_x;
    sample_t     pos_y;
    sample_t     pos_z;
    logic [2:0]  sat_flags;
    sample_t     ctrl_out;
    logic        ctrl_valid;
    logic        dac_sclk;
    logic        dac_cs_n;
    logic        dac_sdo;
    logic        dac_busy;

    int seed = 32'h7526;
    int err_cnt = 0;
    int chk_cnt = 0;
    int test_base = 0;
    int frames_seen = 0;

    // reference model state
    coeff_t      m_kp;
    coeff_t      m_ki;
    logic [15:0] m_kp_lo;
    logic [15:0] m_ki_lo;
    sample_t     m_setpoint;
    sample_t     m_lim_hi;
    sample_t     m_lim_lo;
    sample_t     m_out_dis;
    sample_t     m_xoff;
    sample_t     m_yoff;
    sample_t     m_zoff;
    logic        m_enable;
    logic        m_reset_pend;
    longint      m_integ;
    int          busy_cnt;
    dac_code_t   frame_q [$];

    // expected outputs, aligned with the DUT pipeline
    sample_t    exp_pos_x;
    sample_t    exp_pos_y;
    sample_t    exp_pos_z;
    logic [2:0] exp_flags;
    logic       exp_pos_valid;
    sample_t    ctrl_pipe [0:1];
    logic [1:0] valid_pipe;
    sample_t    exp_ctrl;
    logic       exp_ctrl_valid;

    // serial frame capture
    logic        sclk_prev = 1'b0;
    logic [15:0] frame_word;
    int          frame_bits = 0;

    tweezer_top #(.COEFF_FRAC(COEFF_FRAC), .SCLK_HALF(SCLK_HALF)) tweezer_top_i (
        .clk_adc(clk_adc), .rst_n(rst_n),
        .cfg_wr_en(cfg_wr_en), .cfg_wr_addr(cfg_wr_addr), .cfg_wr_data(cfg_wr_data),
        .sample_valid(sample_valid), .xdiff(xdiff), .ydiff(ydiff), .sum(sum),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z), .sat_flags(sat_flags),
        .ctrl_out(ctrl_out), .ctrl_valid(ctrl_valid),
        .dac_sclk(dac_sclk), .dac_cs_n(dac_cs_n), .dac_sdo(dac_sdo), .dac_busy(dac_busy)
    );

    always #(CLK_PERIOD / 2) clk_adc = ~clk_adc;

    function automatic sample_t clip16(longint v, sample_t hi, sample_t lo);
        if (v > hi) begin
            return hi;
        end
        if (v < lo) begin
            return lo;
        end
        return sample_t'(v);
    endfunction

    function automatic sample_t sat_diff(sample_t a, sample_t b);
        return clip16(longint'(a) - longint'(b), SAMPLE_MAX, SAMPLE_MIN);
    endfunction

    function automatic logic full_scale(sample_t v);
        return (v == SAMPLE_MAX) || (v == SAMPLE_MIN);
    endfunction

    // PI rule for one sample, advances the model integrator
    function automatic sample_t model_ctrl(sample_t z);
        longint err;
        longint p;
        longint i;
        err = longint'(m_setpoint) - longint'(z);
        p = (err * longint'(m_kp)) >>> COEFF_FRAC;
        i = (err * longint'(m_ki)) >>> COEFF_FRAC;
        if (!m_enable) begin
            m_integ = 0;
            return m_out_dis;
        end
        if (m_reset_pend) begin
            m_integ = 0;
            m_reset_pend = 1'b0;
            return clip16(p, m_lim_hi, m_lim_lo);
        end
        m_integ = clip16(m_integ + i, m_lim_hi, m_lim_lo);
        return clip16(p + m_integ, m_lim_hi, m_lim_lo);
    endfunction

    function automatic sample_t rnd16();
        return sample_t'($random(seed));
    endfunction

    always @(posedge clk_adc or negedge rst_n) begin
        if (!rst_n) begin
            m_kp = '0;
            m_ki = '0;
            m_kp_lo = '0;
            m_ki_lo = '0;
            m_setpoint = '0;
            m_lim_hi = SAMPLE_MAX;
            m_lim_lo = SAMPLE_MIN;
            m_out_dis = '0;
            m_xoff = '0;
            m_yoff = '0;
            m_zoff = '0;
            m_enable = 1'b0;
            m_reset_pend = 1'b0;
            m_integ = 0;
            busy_cnt = 0;
            frame_q.delete();
            exp_pos_valid <= 1'b0;
            valid_pipe <= '0;
            exp_ctrl_valid <= 1'b0;
        end else begin
            // DAC takes a controller output only when free
            if (busy_cnt != 0) begin
                busy_cnt = busy_cnt - 1;
            end else if (exp_ctrl_valid) begin
                frame_q.push_back(dac_code_t'(exp_ctrl) + DAC_MIDSCALE);
                busy_cnt = FRAME_CYC;
            end
            exp_pos_valid <= sample_valid;
            valid_pipe <= {valid_pipe[0], sample_valid};
            exp_ctrl_valid <= valid_pipe[1];
            ctrl_pipe[1] <= ctrl_pipe[0];
            exp_ctrl <= ctrl_pipe[1];
            if (sample_valid) begin
                exp_pos_x <= sat_diff(xdiff, m_xoff);
                exp_pos_y <= sat_diff(ydiff, m_yoff);
                exp_pos_z <= sat_diff(sum, m_zoff);
                exp_flags <= {full_scale(sum), full_scale(ydiff), full_scale(xdiff)};
                ctrl_pipe[0] <= model_ctrl(sat_diff(sum, m_zoff));
            end
            if (cfg_wr_en) begin
                case (cfg_wr_addr)
                    REG_KP_LO: m_kp_lo = cfg_wr_data;
                    REG_KP_HI: m_kp = {cfg_wr_data[9:0], m_kp_lo};
                    REG_KI_LO: m_ki_lo = cfg_wr_data;
                    REG_KI_HI: m_ki = {cfg_wr_data[9:0], m_ki_lo};
                    REG_SETPOINT: m_setpoint = cfg_wr_data;
                    REG_LIMIT_HI: m_lim_hi = cfg_wr_data;
                    REG_LIMIT_LO: m_lim_lo = cfg_wr_data;
                    REG_OUT_DISABLED: m_out_dis = cfg_wr_data;
                    REG_X_OFFSET: m_xoff = cfg_wr_data;
                    REG_Y_OFFSET: m_yoff = cfg_wr_data;
                    REG_Z_OFFSET: m_zoff = cfg_wr_data;
                    REG_CONTROL: begin
                        m_enable = cfg_wr_data[CTRL_ENABLE_BIT];
                        m_reset_pend = m_enable && (cfg_wr_data[CTRL_RESET_BIT] || m_reset_pend);
                        // integrator sits at zero while disabled
                        if (!m_enable) begin
                            m_integ = 0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        $display("mismatch %s expected %h got %h", name, exp, got);
        err_cnt = err_cnt + 1;
    endtask

    task automatic note_failure(string msg);
        $display("%s", msg);
        err_cnt = err_cnt + 1;
    endtask

    // outputs are settled at the falling edge
    pos_x_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            exp_pos_valid |-> pos_x == exp_pos_x)
        else report_mismatch("pos_x", exp_pos_x, pos_x);
    pos_y_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            exp_pos_valid |-> pos_y == exp_pos_y)
        else report_mismatch("pos_y", exp_pos_y, pos_y);
    pos_z_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            exp_pos_valid |-> pos_z == exp_pos_z)
        else report_mismatch("pos_z", exp_pos_z, pos_z);
    flags_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            exp_pos_valid |-> sat_flags == exp_flags)
        else report_mismatch("sat_flags", exp_flags, sat_flags);
    valid_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            ctrl_valid == exp_ctrl_valid)
        else report_mismatch("ctrl_valid", exp_ctrl_valid, ctrl_valid);
    ctrl_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            exp_ctrl_valid |-> ctrl_out == exp_ctrl)
        else report_mismatch("ctrl_out", exp_ctrl, ctrl_out);
    busy_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            dac_busy == (busy_cnt != 0))
        else report_mismatch("dac_busy", busy_cnt != 0, dac_busy);
    limit_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            ctrl_valid && m_enable |-> ctrl_out <= m_lim_hi && ctrl_out >= m_lim_lo)
        else note_failure("ctrl_out left the limit window");
    integ_ok: assert property (@(negedge clk_adc) disable iff (!rst_n)
            tweezer_top_i.pi_controller_i.integ <= m_lim_hi &&
            tweezer_top_i.pi_controller_i.integ >= m_lim_lo)
        else note_failure("integrator left the limit window");

    // bits are taken on each rising dac_sclk inside the frame
    always @(negedge clk_adc) begin
        if (rst_n) begin
            if (exp_pos_valid) begin
                chk_cnt = chk_cnt + 4;
            end
            if (exp_ctrl_valid) begin
                chk_cnt = chk_cnt + 1;
            end
            if (dac_sclk && !sclk_prev && !dac_cs_n) begin
                frame_word = {frame_word[14:0], dac_sdo};
                frame_bits = frame_bits + 1;
                if (frame_bits == 16) begin
                    frame_bits = 0;
                    chk_cnt = chk_cnt + 1;
                    if (frame_q.size() == 0) begin
                        note_failure("DAC frame sent without a captured sample");
                    end else begin
                        frames_seen = frames_seen + 1;
                        assert (frame_word == frame_q[0])
                            else report_mismatch("dac_sdo frame", frame_q[0], frame_word);
                        void'(frame_q.pop_front());
                    end
                end
            end
            sclk_prev = dac_sclk;
        end
    end

    task automatic next_cycle();
        @(posedge clk_adc);
        #2;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) next_cycle();
    endtask

    task automatic write_reg(reg_idx_t addr, logic [15:0] data);
        cfg_wr_en = 1'b1;
        cfg_wr_addr = addr;
        cfg_wr_data = data;
        next_cycle();
        cfg_wr_en = 1'b0;
    endtask

    task automatic load_coeff(reg_idx_t lo_addr, coeff_t c);
        write_reg(lo_addr, c[15:0]);
        write_reg(reg_idx_t'(lo_addr + 1), {6'b0, c[25:16]});
    endtask

    task automatic drive_sample(sample_t x, sample_t y, sample_t s);
        sample_valid = 1'b1;
        xdiff = x;
        ydiff = y;
        sum = s;
        next_cycle();
    endtask

    task automatic send_random(int n);
        repeat (n) drive_sample(rnd16(), rnd16(), rnd16());
        sample_valid = 1'b0;
    endtask

    task automatic wait_dac_idle();
        int n;
        n = 0;
        while (dac_busy && n < 2 * FRAME_CYC) begin
            next_cycle();
            n = n + 1;
        end
        if (dac_busy) begin
            note_failure("DAC still busy after two frame lengths");
        end
    endtask

    task automatic end_test(string name);
        $display("%s: %0d errors", name, err_cnt - test_base);
        test_base = err_cnt;
    endtask

    initial begin
        int frame_base;
        coeff_t kp_new;
        rst_n = 1'b0;
        cfg_wr_en = 1'b0;
        cfg_wr_addr = '0;
        cfg_wr_data = '0;
        sample_valid = 1'b0;
        xdiff = '0;
        ydiff = '0;
        sum = '0;
        repeat (16) @(posedge clk_adc);
        #2;
        rst_n = 1'b1;
        idle_cycles(2);

        assert (!ctrl_valid && !dac_busy && dac_cs_n && !dac_sclk)
            else note_failure("outputs not in their reset state");
        write_reg(REG_OUT_DISABLED, 16'h1234);
        send_random(8);
        idle_cycles(4);
        end_test("reset state and disabled output");

        write_reg(REG_X_OFFSET, rnd16());
        write_reg(REG_Y_OFFSET, rnd16());
        write_reg(REG_Z_OFFSET, rnd16());
        send_random(12);
        write_reg(REG_X_OFFSET, 16'hE000);
        write_reg(REG_Y_OFFSET, 16'h2000);
        drive_sample(16'sh7000, -16'sh7000, SAMPLE_MAX);
        drive_sample(SAMPLE_MAX, SAMPLE_MIN, SAMPLE_MIN);
        sample_valid = 1'b0;
        idle_cycles(4);
        end_test("offsets and saturation");

        load_coeff(REG_KP_LO, coeff_t'($random(seed)));
        load_coeff(REG_KI_LO, coeff_t'($random(seed)));
        write_reg(REG_SETPOINT, rnd16());
        write_reg(REG_CONTROL, 16'h0001);
        send_random(24);
        idle_cycles(4);
        end_test("PI arithmetic");

        write_reg(REG_CONTROL, 16'h0000);
        write_reg(REG_LIMIT_HI, 16'd3000);
        write_reg(REG_LIMIT_LO, 16'hF63C);
        load_coeff(REG_KI_LO, 26'sh0800000);
        write_reg(REG_SETPOINT, 16'h0000);
        write_reg(REG_CONTROL, 16'h0001);
        send_random(16);
        idle_cycles(4);
        write_reg(REG_CONTROL, 16'h0003);
        idle_cycles(2);
        send_random(4);
        idle_cycles(4);
        end_test("limits and PI reset");

        kp_new = coeff_t'($random(seed));
        write_reg(REG_KP_LO, kp_new[15:0]);
        send_random(8);
        idle_cycles(4);
        write_reg(REG_KP_HI, {6'b0, kp_new[25:16]});
        send_random(8);
        idle_cycles(4);
        end_test("two-half coefficient writes");

        wait_dac_idle();
        frame_base = frames_seen;
        repeat (4) begin
            send_random(1);
            idle_cycles(4);
            wait_dac_idle();
        end
        // a burst shorter than one frame yields a single frame
        send_random(12);
        idle_cycles(4);
        wait_dac_idle();
        assert (frames_seen - frame_base == 5)
            else note_failure("wrong number of DAC frames");
        assert (frame_q.size() == 0)
            else note_failure("captured DAC samples never sent");
        end_test("DAC frame");

        $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout after %0d cycles, run stopped", WATCHDOG_CYC);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: build.f
verilog/tweezer_pkg.sv
verilog/param_regs.sv
verilog/input_conditioner.sv
verilog/pi_controller.sv
verilog/dac_ad5541a_serializer.sv
verilog/tweezer_top.sv
verification/tweezer_tb.sv

// File: Makefile
# Verilator simulation of the tweezer feedback path

TOP := tweezer_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } $$0 == "All checks passed" { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
